// ==== compile.f ====
+incdir+.
iis_audio_pkg.sv
iis_ctrl_pkg.sv
iis_shift_reg.sv
iis_clock_gen.sv
iis_frame_ctrl.sv
iis_dummy_device.sv
iis_loopback_top.sv
iis_properties.sv
tb_iis_loopback.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the I2S loopback simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_iis_loopback
./obj_dir/Vtb_iis_loopback 2>&1 | tee sim.log

if grep -q 'All tests passed!' sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED, see sim.log"
  exit 1
fi

// ==== tb_iis_loopback.sv ====
// Testbench for the I2S handler looped back through the dummy codec
// Applies a table of stereo pairs, checks both data paths, frame rate and stop
`timescale 1ns/10ps
`include "iis_consts.svh"

module tb_iis_loopback;
  import iis_audio_pkg::*;

  localparam int num_vecs     = 6;
  localparam int wait_limit   = 1000;  // Cycles allowed per frame_done wait
  localparam int stop_limit   = 400;
  localparam int slot_cycles  = 2 * `IIS_SLOT_BCLKS * `IIS_BCLK_HALF;
  localparam int frame_cycles = 2 * slot_cycles;  // Left plus right slot

  // Stimulus and the values the loopback must return
  typedef struct packed {
    sample_t tx_left;
    sample_t tx_right;
    sample_t in_left;
    sample_t in_right;
    sample_t exp_out_left;   // Codec capture of the DAC path
    sample_t exp_out_right;
    sample_t exp_rx_left;    // Handler capture of the ADC path
    sample_t exp_rx_right;
  } vec_t;

  logic    clk_i = 1'b0;
  logic    rst_ni;
  logic    en;
  sample_t tx_left, tx_right, test_in_left, test_in_right;
  sample_t rx_left, rx_right, test_out_left, test_out_right;
  logic    frame_done, bclk, lrclk;

  vec_t        table_q [num_vecs];
  logic [31:0] lcg_state = 32'd8244;
  int          errors = 0;
  int          tests = 0;
  int          failed_tests = 0;

  iis_loopback_top uut (
    .clk_i, .rst_ni, .en, .tx_left, .tx_right, .test_in_left, .test_in_right,
    .rx_left, .rx_right, .test_out_left, .test_out_right, .frame_done, .bclk, .lrclk
  );

  always #4 clk_i = ~clk_i;  // 8 ns period

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic rand_sample(output sample_t s);
    lcg_state = lcg_next(lcg_state);
    s = lcg_state[31:16];  // Upper bits have the longer period
  endtask

  // DAC data comes back on test_out and ADC data on rx
  function automatic vec_t make_vec(input sample_t tl, input sample_t tr,
                                    input sample_t il, input sample_t ir);
    vec_t v;
    v.tx_left       = tl;
    v.tx_right      = tr;
    v.in_left       = il;
    v.in_right      = ir;
    v.exp_out_left  = tl;
    v.exp_out_right = tr;
    v.exp_rx_left   = il;
    v.exp_rx_right  = ir;
    return v;
  endfunction

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("[ERROR] %0t ns: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  // Samples on the falling clock and returns the cycles waited
  task automatic wait_frame_done(output int cycles);
    bit seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < wait_limit) begin
      @(negedge clk_i);
      cycles++;
      seen = frame_done;
    end
    if (!seen) begin
      $display("%0t ns: frame_done never arrived within %0d cycles", $time, wait_limit);
      errors++;
    end
  endtask

  task automatic end_test(input string label, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("test %0d %s: ok", tests, label);
    end else begin
      $display("test %0d %s: FAILED", tests, label);
      failed_tests++;
    end
  endtask

  initial begin
    sample_t r [4];
    int      cycles;
    int      errs_at;
    int      quiet;
    int      n;
    rst_ni        = 1'b0;
    en            = 1'b0;
    tx_left       = '0;
    tx_right      = '0;
    test_in_left  = '0;
    test_in_right = '0;

    // Distinct left and right values expose swapped channels
    table_q[0] = make_vec(16'h0000, 16'hFFFF, 16'hFFFF, 16'h0000);
    table_q[1] = make_vec(16'h8001, 16'hA5C3, 16'hA5C3, 16'h8001);
    table_q[2] = make_vec(16'hA5C3, 16'h8001, 16'h8001, 16'hFFFF);
    table_q[3] = make_vec(16'hFFFF, 16'h0000, 16'h0000, 16'h8001);
    for (int k = 4; k < num_vecs; k++) begin
      for (int j = 0; j < 4; j++) rand_sample(r[j]);
      table_q[k] = make_vec(r[0], r[1], r[2], r[3]);
    end

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (2) @(negedge clk_i);
    errs_at = errors;
    check_bit("frame_done", frame_done, 1'b0);
    check_bit("bclk", bclk, 1'b0);
    check_bit("lrclk", lrclk, 1'b0);
    check_sample("rx_left", rx_left, '0);
    check_sample("rx_right", rx_right, '0);
    check_sample("test_out_left", test_out_left, '0);
    check_sample("test_out_right", test_out_right, '0);
    end_test("idle after reset", errs_at);

    for (int k = 0; k < num_vecs; k++) begin
      @(posedge clk_i);
      en            <= 1'b1;
      tx_left       <= table_q[k].tx_left;
      tx_right      <= table_q[k].tx_right;
      test_in_left  <= table_q[k].in_left;
      test_in_right <= table_q[k].in_right;
      errs_at = errors;
      wait_frame_done(cycles);
      wait_frame_done(cycles);  // Second frame carries only the new pair
      @(negedge clk_i);  // rx_right is written at the end of the pulse cycle
      check_sample("test_out_left", test_out_left, table_q[k].exp_out_left);
      check_sample("test_out_right", test_out_right, table_q[k].exp_out_right);
      check_sample("rx_left", rx_left, table_q[k].exp_rx_left);
      check_sample("rx_right", rx_right, table_q[k].exp_rx_right);
      end_test($sformatf("vector %0d loopback", k), errs_at);
      errs_at = errors;
      check_count("frame_done spacing", cycles, frame_cycles);
      end_test($sformatf("vector %0d frame rate", k), errs_at);
    end

    @(posedge clk_i);
    en <= 1'b0;
    errs_at = errors;
    quiet   = 0;
    n       = 0;
    // Bus must fall silent and then stay quiet for a whole slot
    while (quiet < slot_cycles && n < stop_limit) begin
      @(negedge clk_i);
      n++;
      quiet = (bclk || lrclk || frame_done) ? 0 : quiet + 1;
    end
    if (quiet < slot_cycles) begin
      $display("%0t ns: bus kept running %0d cycles after en fell", $time, stop_limit);
      errors++;
    end
    end_test("stop after en falls", errs_at);

    $display("Summary: %0d tests, %0d failed, %0d check errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== iis_properties.sv ====
// Bus timing assertions for the I2S loopback top
// Bound into every iis_loopback_top instance
`timescale 1ns/10ps

module iis_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic bclk_fall,
  input logic lrclk,
  input logic frame_done
);

  // LRCLK toggles only together with a BCLK fall
  a_lrclk_after_fall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $changed(lrclk) |-> $past(bclk_fall))
    else $error("lrclk changed without a preceding bclk fall");

  a_frame_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    frame_done |=> !frame_done)
    else $error("frame_done high for two cycles in a row");

  // Frame ends inside the right slot
  a_frame_done_right: assert property (@(posedge clk_i) disable iff (!rst_ni)
    frame_done |-> lrclk)
    else $error("frame_done outside the right slot");

endmodule

bind iis_loopback_top iis_properties u_props (
  .clk_i(clk_i), .rst_ni(rst_ni), .bclk_fall(bclk_fall),
  .lrclk(lrclk), .frame_done(frame_done)
);

// ==== iis_loopback_top.sv ====
// I2S handler wired in loopback to the dummy codec
// The handler drives the bus clocks, the codec echoes and supplies data
`timescale 1ns/10ps

module iis_loopback_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   en,
  input  iis_audio_pkg::sample_t tx_left,
  input  iis_audio_pkg::sample_t tx_right,
  input  iis_audio_pkg::sample_t test_in_left,
  input  iis_audio_pkg::sample_t test_in_right,
  output iis_audio_pkg::sample_t rx_left,
  output iis_audio_pkg::sample_t rx_right,
  output iis_audio_pkg::sample_t test_out_left,
  output iis_audio_pkg::sample_t test_out_right,
  output logic                   frame_done,
  output logic                   bclk,
  output logic                   lrclk
);
  import iis_audio_pkg::*;
  import iis_ctrl_pkg::*;

  logic     bclk_rise, bclk_fall, slot_start;
  bit_idx_t bit_idx;
  logic     load_tx, shift_tx, shift_rx;
  logic     cap_left, cap_right;
  channel_e tx_sel;
  sample_t  tx_sample;  // Sample for the slot being opened
  sample_t  rx_sample;
  logic     dac_sdata, adc_sdata;

  assign tx_sample = (tx_sel == RIGHT) ? tx_right : tx_left;

  iis_clock_gen u_clock_gen (
    .clk_i, .rst_ni, .en, .bclk, .lrclk, .bclk_rise, .bclk_fall, .slot_start, .bit_idx
  );

  iis_frame_ctrl u_frame_ctrl (
    .clk_i, .rst_ni, .en, .bclk_rise, .bclk_fall, .slot_start, .lrclk, .bit_idx,
    .load_tx, .shift_tx, .shift_rx, .cap_left, .cap_right, .frame_done, .tx_sel
  );

  iis_shift_reg #(.payload_t(sample_t)) u_tx_ser (
    .clk_i, .rst_ni, .load(load_tx), .load_value(tx_sample), .shift(shift_tx),
    .serial_in(1'b0), .value(), .serial_out(dac_sdata)
  );

  // Deserializer never loads
  iis_shift_reg #(.payload_t(sample_t)) u_rx_des (
    .clk_i, .rst_ni, .load(1'b0), .load_value('0), .shift(shift_rx),
    .serial_in(adc_sdata), .value(rx_sample), .serial_out()
  );

  iis_dummy_device u_codec (
    .clk_i, .rst_ni, .bclk, .lrclk, .dac_sdata, .adc_sdata,
    .test_in_left, .test_in_right, .test_out_left, .test_out_right
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_left  <= '0;
      rx_right <= '0;
    end else begin
      if (cap_left)  rx_left  <= rx_sample;
      if (cap_right) rx_right <= rx_sample;
    end
  end

endmodule

// ==== iis_dummy_device.sv ====
// Stereo dummy codec used as the far end of the I2S handler
// Captures DAC data to test outputs and plays test inputs on the ADC line
`timescale 1ns/10ps
`include "iis_consts.svh"

module iis_dummy_device (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   bclk,
  input  logic                   lrclk,
  input  logic                   dac_sdata,
  output logic                   adc_sdata,
  input  iis_audio_pkg::sample_t test_in_left,
  input  iis_audio_pkg::sample_t test_in_right,
  output iis_audio_pkg::sample_t test_out_left,
  output iis_audio_pkg::sample_t test_out_right
);
  import iis_audio_pkg::*;

  localparam logic [4:0] store_cnt = 5'(`IIS_SAMPLE_WIDTH + 1);

  logic       bclk_last;
  logic       lrclk_last;
  logic       bclk_rise_d;   // Registered edge flags lag one cycle
  logic       bclk_fall_d;
  logic       lrclk_rise_d;
  logic       lrclk_fall_d;
  logic       lrclk_edge;
  logic [4:0] rise_cnt;      // BCLK rises since the last LRCLK edge
  logic       rx_bit;        // Current rise carries a data bit
  sample_t    rx_word;
  tx_word_t   tx_next;
  logic       tx_shift;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bclk_last    <= 1'b0;
      lrclk_last   <= 1'b0;
      bclk_rise_d  <= 1'b0;
      bclk_fall_d  <= 1'b0;
      lrclk_rise_d <= 1'b0;
      lrclk_fall_d <= 1'b0;
    end else begin
      bclk_last    <= bclk;
      lrclk_last   <= lrclk;
      bclk_rise_d  <= bclk && !bclk_last;
      bclk_fall_d  <= !bclk && bclk_last;
      lrclk_rise_d <= lrclk && !lrclk_last;
      lrclk_fall_d <= !lrclk && lrclk_last;
    end
  end

  assign lrclk_edge = lrclk_rise_d || lrclk_fall_d;
  assign rx_bit     = bclk_rise_d && !lrclk_edge &&
                      (rise_cnt >= 5'd1) && (rise_cnt <= 5'(`IIS_SAMPLE_WIDTH));

  // Counts rises and stores the word on the first rise after bit 16
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rise_cnt       <= '0;
      test_out_left  <= '0;
      test_out_right <= '0;
    end else if (lrclk_edge) begin
      rise_cnt <= '0;
    end else if (bclk_rise_d) begin
      rise_cnt <= rise_cnt + 1'b1;
      if (rise_cnt == store_cnt) begin
        if (lrclk) test_out_right <= rx_word;
        else       test_out_left  <= rx_word;
      end
    end
  end

  // Receive shift register for the DAC bits
  always_ff @(posedge clk_i) begin
    if (rx_bit) rx_word <= {rx_word[`IIS_SAMPLE_WIDTH-2:0], dac_sdata};
  end

  // Word for the slot that has just begun
  assign tx_next  = lrclk ? tx_word_t'{delay_bit: 1'b0, sample: test_in_right}
                          : tx_word_t'{delay_bit: 1'b0, sample: test_in_left};
  assign tx_shift = bclk_fall_d && !lrclk_edge;

  iis_shift_reg #(
    .payload_t (tx_word_t)
  ) u_tx_sr (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .load       (lrclk_edge),
    .load_value (tx_next),
    .shift      (tx_shift),
    .serial_in  (1'b0),
    .value      (),
    .serial_out (adc_sdata)
  );

endmodule

// ==== iis_frame_ctrl.sv ====
// Frame controller of the I2S handler
// Turns clock-gen strobes into serializer, deserializer and capture controls
`timescale 1ns/10ps
`include "iis_consts.svh"

module iis_frame_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    en,
  input  logic                    bclk_rise,
  input  logic                    bclk_fall,
  input  logic                    slot_start,
  input  logic                    lrclk,
  input  iis_ctrl_pkg::bit_idx_t  bit_idx,
  output logic                    load_tx,
  output logic                    shift_tx,
  output logic                    shift_rx,
  output logic                    cap_left,
  output logic                    cap_right,
  output logic                    frame_done,
  output iis_audio_pkg::channel_e tx_sel
);
  import iis_audio_pkg::*;
  import iis_ctrl_pkg::*;

  localparam bit_idx_t last_data = bit_idx_t'(`IIS_SAMPLE_WIDTH);

  frame_state_e state_q;
  frame_state_e state_d;
  logic         last_rx;  // 16th rx bit sampled this cycle

  // A new slot opens unless the right slot ends with en low
  // In SYNC the clocks start fresh, so the first slot is left
  assign load_tx = slot_start && ((state_q == SYNC && !lrclk) ||
                                  (state_q == PAD && (!lrclk || en)));

  // LRCLK still holds the old channel during slot_start
  assign tx_sel = (state_q == PAD) ? channel_e'(~lrclk) : LEFT;

  assign shift_tx = (state_q == DATA) && bclk_fall;  // Falls with bit_idx 1..16
  assign shift_rx = (state_q == DATA) && bclk_rise;  // Rises with bit_idx 1..16
  assign last_rx  = shift_rx && (bit_idx == last_data);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (en) state_d = SYNC;
      SYNC:    if (load_tx) state_d = DELAY;
      DELAY:   if (bclk_fall && bit_idx == '0) state_d = DATA;
      DATA:    if (bclk_fall && bit_idx == last_data) state_d = PAD;
      PAD: begin
        if (load_tx) state_d = DELAY;
        else if (slot_start) state_d = IDLE;  // Frame over and en low
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      cap_left  <= 1'b0;
      cap_right <= 1'b0;
    end else begin
      state_q   <= state_d;
      cap_left  <= last_rx && !lrclk;  // LRCLK low is the left slot
      cap_right <= last_rx && lrclk;
    end
  end

  // Right slot closes the frame
  assign frame_done = cap_right;

endmodule

// ==== iis_clock_gen.sv ====
// Bus clock generator of the I2S handler
// Divides clk_i into BCLK and LRCLK and flags the edges one cycle ahead
`timescale 1ns/10ps
`include "iis_consts.svh"

module iis_clock_gen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   en,
  output logic                   bclk,
  output logic                   lrclk,
  output logic                   bclk_rise,
  output logic                   bclk_fall,
  output logic                   slot_start,
  output iis_ctrl_pkg::bit_idx_t bit_idx
);
  import iis_ctrl_pkg::*;

  localparam int unsigned div_w = $clog2(`IIS_BCLK_HALF);
  localparam logic [div_w-1:0] div_last = div_w'(`IIS_BCLK_HALF - 1);
  localparam bit_idx_t last_bit = bit_idx_t'(`IIS_SLOT_BCLKS - 1);

  logic             running;     // Clocks active
  logic             first_slot;  // Next slot start is the first after enable
  logic [div_w-1:0] div_cnt;
  bit_idx_t         slot_cnt;    // BCLK falls since slot start
  logic             tick;        // BCLK toggles at the end of this cycle

  assign tick       = running && (div_cnt == div_last);
  assign bclk_rise  = tick && !bclk;
  assign bclk_fall  = tick && bclk;
  assign slot_start = bclk_fall && (slot_cnt == last_bit);  // Slot wraps on this fall
  assign bit_idx    = slot_cnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running    <= 1'b0;
      first_slot <= 1'b0;
      div_cnt    <= '0;
      bclk       <= 1'b0;
      lrclk      <= 1'b0;
      slot_cnt   <= last_bit;  // So the first fall opens a slot
    end else if (!running) begin
      if (en) begin
        running    <= 1'b1;
        first_slot <= 1'b1;
        div_cnt    <= '0;
      end
    end else begin
      div_cnt <= tick ? '0 : div_cnt + 1'b1;
      if (tick) bclk <= ~bclk;
      if (bclk_fall) slot_cnt <= slot_start ? '0 : slot_cnt + 1'b1;
      if (slot_start) begin
        first_slot <= 1'b0;
        lrclk      <= ~lrclk & ~first_slot;  // First slot stays left
        // Stop only at the end of a right slot, leaving both clocks low
        if (lrclk && !en) begin
          running  <= 1'b0;
          slot_cnt <= last_bit;
        end
      end
    end
  end

endmodule

// ==== iis_shift_reg.sv ====
// Parallel-load shift register, MSB out first
// Serves as serializer or deserializer for any packed payload type
`timescale 1ns/10ps
`include "iis_consts.svh"

module iis_shift_reg #(
  parameter type payload_t = logic [`IIS_SAMPLE_WIDTH-1:0]
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     load,
  input  payload_t load_value,
  input  logic     shift,
  input  logic     serial_in,
  output payload_t value,
  output logic     serial_out
);

  localparam int unsigned w = $bits(payload_t);

  logic [w-1:0] bits_q;

  // Cleared so the serial line idles low
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bits_q <= '0;
    end else if (load) begin
      bits_q <= load_value;  // Load wins over shift
    end else if (shift) begin
      bits_q <= {bits_q[w-2:0], serial_in};
    end
  end

  assign value      = payload_t'(bits_q);
  assign serial_out = bits_q[w-1];

endmodule

// ==== iis_ctrl_pkg.sv ====
// Sequencing types for the handler's frame controller
// Import where FSM state or slot bit position is handled
`include "iis_consts.svh"

package iis_ctrl_pkg;

  // Frame controller states
  typedef enum logic [2:0] {
    IDLE,   // Bus stopped
    SYNC,   // Waiting for the first left slot
    DELAY,  // One-bit delay after LRCLK edge
    DATA,   // Sample bits on the wire
    PAD     // Unused tail of the slot
  } frame_state_e;

  // Bit position inside a slot, 0 is the delay bit
  typedef logic [$clog2(`IIS_SLOT_BCLKS)-1:0] bit_idx_t;

endpackage

// ==== iis_audio_pkg.sv ====
// Audio payload types shared by the handler and the dummy codec
// Import where samples or channel selects are handled
`include "iis_consts.svh"

package iis_audio_pkg;

  // One channel sample
  typedef logic [`IIS_SAMPLE_WIDTH-1:0] sample_t;

  // Codec transmit word, zero delay bit ahead of the sample
  typedef struct packed {
    logic    delay_bit;  // Sent during the bit after LRCLK toggles
    sample_t sample;
  } tx_word_t;

  // Slot channel, matches the LRCLK level
  typedef enum logic {
    LEFT  = 1'b0,
    RIGHT = 1'b1
  } channel_e;

endpackage

// ==== iis_consts.svh ====
// Shared sizing constants for the I2S loopback design
// Include wherever sample width or bus timing is needed
`ifndef IIS_CONSTS_SVH
`define IIS_CONSTS_SVH

// Bits per channel sample, MSB first on the wire
`define IIS_SAMPLE_WIDTH 16

// clk_i cycles per BCLK half period
`define IIS_BCLK_HALF 4

// BCLK periods per channel slot, delay bit and padding included
`define IIS_SLOT_BCLKS 20

`endif
